//--- vlog.f
+incdir+sim
verilog/cache_pkg.sv
verilog/way_select.sv
verilog/mesi_next.sv
verilog/cache_array.sv
verilog/cache_stats.sv
verilog/cache_top.sv
sim/tb_cache_top.sv

//--- Bender.yml
package:
  name: cache_tag_model

sources:
  - verilog/cache_pkg.sv
  - verilog/way_select.sv
  - verilog/mesi_next.sv
  - verilog/cache_array.sv
  - verilog/cache_stats.sv
  - verilog/cache_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cache_top.sv

//--- sim/tb_cache_model.svh
// reference model of the instruction and data tag arrays that the cache testbench module includes
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

localparam int MODEL_SETS = 1 << SET_BITS;   // SET_BITS comes from the including testbench

typedef struct packed {
    logic       rsp;     // a response is due one cycle later
    cmd_t       cmd;
    addr_t      addr;
    logic       hit;
    logic [2:0] way;
    mesi_t      mesi;
    logic       evict;
    logic       wb;
} expect_t;

// index 0 is the data array, index 1 the instruction array
line_tag_t ref_tag   [2][MODEL_SETS][8];
mesi_t     ref_state [2][MODEL_SETS][8];
int        ref_lru   [2][MODEL_SETS][8];
int        ref_reads;
int        ref_writes;
int        ref_hits;
int        ref_misses;

function automatic void model_clear();
    for (int c = 0; c < 2; c++) begin
        for (int s = 0; s < MODEL_SETS; s++) begin
            for (int w = 0; w < 8; w++) begin
                ref_tag[c][s][w]   = '0;
                ref_state[c][s][w] = MESI_I;
                ref_lru[c][s][w]   = w;     // starting age is the way number
            end
        end
    end
endfunction

function automatic void model_reset();
    model_clear();
    ref_reads  = 0;
    ref_writes = 0;
    ref_hits   = 0;
    ref_misses = 0;
endfunction

// applies one command and returns the response the cache must give for it
function automatic expect_t model_apply(cmd_t cmd, addr_t addr);
    expect_t   e;
    int        c;
    int        ways;
    int        set_idx;
    int        way;
    int        old_cnt;
    line_tag_t tag;
    mesi_t     old;
    logic      access;
    e      = '0;
    e.rsp  = (cmd != CMD_CLEAR);
    e.cmd  = cmd;
    e.addr = addr;
    if (cmd == CMD_CLEAR) begin
        model_clear();
        return e;
    end
    c       = (cmd == CMD_FETCH) ? 1 : 0;
    ways    = (c == 1) ? 4 : 8;
    set_idx = addr[OFFSET_W +: SET_BITS];
    tag     = addr[ADDR_W-1:OFFSET_W];
    access  = (cmd == CMD_READ) || (cmd == CMD_WRITE) || (cmd == CMD_FETCH);
    way     = -1;
    for (int w = ways - 1; w >= 0; w--) begin
        if (ref_state[c][set_idx][w] != MESI_I && ref_tag[c][set_idx][w] == tag) way = w;
    end
    e.hit = (way >= 0);
    if (!e.hit) begin
        for (int w = ways - 1; w >= 0; w--) begin
            if (ref_lru[c][set_idx][w] == 0) way = w;
        end
        for (int w = ways - 1; w >= 0; w--) begin
            if (ref_state[c][set_idx][w] == MESI_I) way = w;   // free way beats LRU
        end
    end
    if (access) begin
        if (cmd == CMD_WRITE) ref_writes++;
        else ref_reads++;
        if (e.hit) ref_hits++;
        else ref_misses++;
    end
    if (!e.hit && !access) return e;   // invalidate or snoop misses allocate nothing
    old   = ref_state[c][set_idx][way];
    e.way = 3'(way);
    case (cmd)
        CMD_WRITE:    e.mesi = MESI_M;
        CMD_INVAL:    e.mesi = MESI_I;
        CMD_SNOOP_RD: e.mesi = (old == MESI_M || old == MESI_E) ? MESI_S : old;
        default:      e.mesi = e.hit ? old : MESI_E;
    endcase
    e.evict = access && !e.hit && (old != MESI_I);
    e.wb    = (old == MESI_M) && (e.evict || !access);
    ref_state[c][set_idx][way] = e.mesi;
    if (!e.hit) ref_tag[c][set_idx][way] = tag;
    if (access) begin
        old_cnt = ref_lru[c][set_idx][way];
        for (int w = 0; w < ways; w++) begin
            if (w == way) ref_lru[c][set_idx][w] = ways - 1;
            else if (ref_lru[c][set_idx][w] > old_cnt) ref_lru[c][set_idx][w]--;
        end
    end
    return e;
endfunction

`endif

//--- sim/tb_cache_top.sv
// testbench for cache_top with directed LRU and MESI cases plus a random trace against a reference model
`timescale 1ns/100ps

module tb_cache_top import cache_pkg::*; ();

    localparam int SET_BITS      = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int DIRECTED_CMDS = 65;
    localparam int RANDOM_CMDS   = 400;
    localparam int CYCLE_LIMIT   = 2 * (DIRECTED_CMDS + RANDOM_CMDS) + RESET_CYCLES + 100;

    logic       clk;
    logic       i_reset;
    logic       i_cmd_valid;
    cmd_t       i_cmd;
    addr_t      i_addr;
    logic       o_rsp_valid;
    logic       o_hit;
    logic [2:0] o_way;
    mesi_t      o_mesi;
    logic       o_evict;
    logic       o_writeback;
    count_t     o_reads;
    count_t     o_writes;
    count_t     o_hits;
    count_t     o_misses;

    `include "tb_cache_model.svh"

    expect_t     exp_q [$];   // expectations in issue order
    expect_t     due;         // command issued one cycle before the current one
    logic        due_valid;
    int          errors;
    int          test_errors;
    int          checks;
    int          cycle;
    logic [31:0] lfsr;

    cache_top #(.SET_BITS(SET_BITS)) UUT (
        .clk (clk), .i_reset (i_reset), .i_cmd_valid (i_cmd_valid), .i_cmd (i_cmd),
        .i_addr (i_addr), .o_rsp_valid (o_rsp_valid), .o_hit (o_hit), .o_way (o_way),
        .o_mesi (o_mesi), .o_evict (o_evict), .o_writeback (o_writeback),
        .o_reads (o_reads), .o_writes (o_writes), .o_hits (o_hits), .o_misses (o_misses)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ 32'h8020_0003;
        return next;
    endfunction

    function automatic int take_bits(int n);
        int value;
        value = 0;
        for (int b = 0; b < n; b++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
        return value;
    endfunction

    function automatic addr_t line_addr(int tag_hi, int set_idx);
        return addr_t'((tag_hi << (OFFSET_W + SET_BITS)) | (set_idx << OFFSET_W));
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic value_error(string what, logic [31:0] got, logic [31:0] expected, string ctx);
        $display("MISMATCH at %0t: %s got %0d expected %0d (%s)", $time, what, got, expected, ctx);
        count_error();
    endtask

    task automatic check_response(expect_t e);
        string ctx;
        ctx = $sformatf("cmd %0d addr %h", e.cmd, e.addr);
        checks++;
        if (o_rsp_valid !== 1'b1) begin
            $display("error at %0t: no response one cycle after %s", $time, ctx);
            count_error();
        end else begin
            if (o_hit !== e.hit) value_error("hit", o_hit, e.hit, ctx);
            if (o_way !== e.way) value_error("way", o_way, e.way, ctx);
            if (o_mesi !== e.mesi) value_error("state", o_mesi, e.mesi, ctx);
            if (o_evict !== e.evict) value_error("evict", o_evict, e.evict, ctx);
            if (o_writeback !== e.wb) value_error("writeback", o_writeback, e.wb, ctx);
        end
    endtask

    // outputs are compared mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (!i_reset) begin
            if (due_valid && due.rsp) begin
                check_response(due);
            end else if (o_rsp_valid !== 1'b0) begin
                $display("error at %0t: response valid with no command one cycle earlier", $time);
                count_error();
            end
            due_valid = 1'b0;
            if (exp_q.size() != 0) begin
                due       = exp_q.pop_front();
                due_valid = 1'b1;
            end
        end
    end

    task automatic issue_cmd(cmd_t cmd, addr_t addr);
        @(posedge clk);
        i_cmd_valid <= 1'b1;
        i_cmd       <= cmd;
        i_addr      <= addr;
        exp_q.push_back(model_apply(cmd, addr));
    endtask

    task automatic drain();
        @(posedge clk);
        i_cmd_valid <= 1'b0;
        while (exp_q.size() != 0 || due_valid) @(negedge clk);
    endtask

    task automatic report_test(string name);
        $display("test %-14s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic fill_then_hit();
        for (int t = 1; t <= 8; t++) issue_cmd(CMD_READ, line_addr(t, 3));   // ways 0..7
        for (int t = 1; t <= 8; t++) issue_cmd(CMD_READ, line_addr(t, 3));
        for (int t = 1; t <= 4; t++) issue_cmd(CMD_FETCH, line_addr(t, 3));
        for (int t = 1; t <= 4; t++) issue_cmd(CMD_FETCH, line_addr(t, 3));
    endtask

    task automatic lru_replace();
        issue_cmd(CMD_READ, line_addr(4, 3));     // way 3
        issue_cmd(CMD_READ, line_addr(1, 3));     // way 0
        issue_cmd(CMD_READ, line_addr(7, 3));     // way 6
        issue_cmd(CMD_READ, line_addr(20, 3));    // new tag takes the oldest way
        issue_cmd(CMD_READ, line_addr(21, 3));
        issue_cmd(CMD_FETCH, line_addr(3, 3));
        issue_cmd(CMD_FETCH, line_addr(1, 3));
        issue_cmd(CMD_FETCH, line_addr(9, 3));
    endtask

    task automatic mesi_sequence();
        issue_cmd(CMD_READ, line_addr(1, 7));
        issue_cmd(CMD_WRITE, line_addr(1, 7));      // E to M
        issue_cmd(CMD_SNOOP_RD, line_addr(1, 7));   // M to S with dirty data out
        issue_cmd(CMD_SNOOP_RD, line_addr(1, 7));
        issue_cmd(CMD_WRITE, line_addr(2, 7));      // write miss fills as M
        for (int t = 3; t <= 8; t++) issue_cmd(CMD_READ, line_addr(t, 7));
        issue_cmd(CMD_READ, line_addr(9, 7));       // pushes out the S line
        issue_cmd(CMD_READ, line_addr(10, 7));      // then the M line
    endtask

    task automatic inval_and_clear();
        issue_cmd(CMD_READ, line_addr(1, 9));
        issue_cmd(CMD_INVAL, line_addr(1, 9));
        issue_cmd(CMD_READ, line_addr(1, 9));
        issue_cmd(CMD_WRITE, line_addr(1, 9));
        issue_cmd(CMD_INVAL, line_addr(1, 9));      // dirty line dropped
        issue_cmd(CMD_INVAL, line_addr(11, 7));     // full set, the victim would be way 2 in E
        issue_cmd(CMD_CLEAR, '0);
        for (int t = 1; t <= 8; t++) issue_cmd(CMD_READ, line_addr(t, 3));
        issue_cmd(CMD_READ, line_addr(20, 3));
        for (int t = 1; t <= 4; t++) issue_cmd(CMD_FETCH, line_addr(t, 3));
    endtask

    task automatic random_mix();
        int   pick;
        int   tag_hi;
        int   set_idx;
        int   offset;
        cmd_t cmd;
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            pick = take_bits(5);
            if (pick == 0) cmd = CMD_CLEAR;           // rare
            else if (pick < 9) cmd = CMD_READ;
            else if (pick < 17) cmd = CMD_WRITE;
            else if (pick < 24) cmd = CMD_FETCH;
            else if (pick < 28) cmd = CMD_INVAL;
            else cmd = CMD_SNOOP_RD;
            tag_hi  = take_bits(4);
            set_idx = take_bits(2);
            offset  = take_bits(OFFSET_W);
            issue_cmd(cmd, line_addr(tag_hi, set_idx) | addr_t'(offset));
        end
    endtask

    task automatic check_stats();
        @(negedge clk);   // counters trail the last response by a cycle
        checks++;
        if (o_reads !== count_t'(ref_reads)) value_error("reads", o_reads, ref_reads, "stats");
        if (o_writes !== count_t'(ref_writes)) value_error("writes", o_writes, ref_writes, "stats");
        if (o_hits !== count_t'(ref_hits)) value_error("hits", o_hits, ref_hits, "stats");
        if (o_misses !== count_t'(ref_misses)) value_error("misses", o_misses, ref_misses, "stats");
    endtask

    initial begin
        clk         = 1'b0;
        i_reset     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd       = CMD_READ;
        i_addr      = '0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        cycle       = 0;
        due_valid   = 1'b0;
        due         = '0;
        lfsr        = 32'hb46e;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        fill_then_hit();
        drain();
        report_test("fill_then_hit");
        lru_replace();
        drain();
        report_test("lru_replace");
        mesi_sequence();
        drain();
        report_test("mesi_sequence");
        inval_and_clear();
        drain();
        report_test("inval_clear");
        random_mix();
        drain();
        check_stats();
        report_test("random_mix");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog/cache_top.sv
// split L1 tag model that decodes trace commands into the instruction and data arrays
`timescale 1ns/100ps

module cache_top import cache_pkg::*; #(
    parameter int SET_BITS = 4
) (
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_cmd_valid,
    input  cmd_t   i_cmd,
    input  addr_t  i_addr,
    output logic   o_rsp_valid,
    output logic   o_hit,
    output logic [2:0] o_way,
    output mesi_t  o_mesi,
    output logic   o_evict,
    output logic   o_writeback,
    output count_t o_reads,
    output count_t o_writes,
    output count_t o_hits,
    output count_t o_misses
);

    line_tag_t           line_tag;
    logic [SET_BITS-1:0] set_idx;
    logic                ic_req;
    logic                dc_req;
    logic                clear;
    logic                route_i_q;   // response comes from the instruction array
    cmd_t                cmd_q;

    logic       ic_rsp_valid, dc_rsp_valid;
    logic       ic_hit, dc_hit;
    logic [2:0] ic_way, dc_way;
    mesi_t      ic_mesi, dc_mesi;
    logic       ic_evict, dc_evict;
    logic       ic_wb, dc_wb;

    assign line_tag = i_addr[ADDR_W-1:OFFSET_W];
    assign set_idx  = i_addr[OFFSET_W +: SET_BITS];   // index right above the line offset

    assign ic_req = i_cmd_valid && (i_cmd == CMD_FETCH);
    assign dc_req = i_cmd_valid && cmd_is_data(i_cmd);
    assign clear  = i_cmd_valid && (i_cmd == CMD_CLEAR);  // wipes both arrays

    cache_array #(.WAYS(4), .SET_BITS(SET_BITS)) u_icache (
        .clk (clk), .i_reset (i_reset), .i_req (ic_req), .i_clear (clear),
        .i_cmd (i_cmd), .i_set (set_idx), .i_tag (line_tag),
        .o_rsp_valid (ic_rsp_valid), .o_hit (ic_hit), .o_way (ic_way),
        .o_mesi (ic_mesi), .o_evict (ic_evict), .o_writeback (ic_wb)
    );

    cache_array #(.WAYS(8), .SET_BITS(SET_BITS)) u_dcache (
        .clk (clk), .i_reset (i_reset), .i_req (dc_req), .i_clear (clear),
        .i_cmd (i_cmd), .i_set (set_idx), .i_tag (line_tag),
        .o_rsp_valid (dc_rsp_valid), .o_hit (dc_hit), .o_way (dc_way),
        .o_mesi (dc_mesi), .o_evict (dc_evict), .o_writeback (dc_wb)
    );

    always_ff @(posedge clk) begin
        if (i_reset) route_i_q <= 1'b0;
        else if (i_cmd_valid) route_i_q <= (i_cmd == CMD_FETCH);
    end

    always_ff @(posedge clk) begin
        if (i_cmd_valid) cmd_q <= i_cmd;   // lines up with the array response
    end

    // only one array answers in a given cycle
    assign o_rsp_valid = ic_rsp_valid || dc_rsp_valid;
    assign o_hit       = route_i_q ? ic_hit   : dc_hit;
    assign o_way       = route_i_q ? ic_way   : dc_way;
    assign o_mesi      = route_i_q ? ic_mesi  : dc_mesi;
    assign o_evict     = route_i_q ? ic_evict : dc_evict;
    assign o_writeback = route_i_q ? ic_wb    : dc_wb;

    cache_stats u_stats (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_rsp_valid (o_rsp_valid),
        .i_cmd       (cmd_q),
        .i_hit       (o_hit),
        .o_reads     (o_reads),
        .o_writes    (o_writes),
        .o_hits      (o_hits),
        .o_misses    (o_misses)
    );

endmodule

//--- verilog/cache_stats.sv
// run-wide read, write, hit and miss counters fed by the merged cache response
`timescale 1ns/100ps

module cache_stats import cache_pkg::*; (
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_rsp_valid,
    input  cmd_t   i_cmd,        // command of the response now on the outputs
    input  logic   i_hit,
    output count_t o_reads,
    output count_t o_writes,
    output count_t o_hits,
    output count_t o_misses
);

    logic inc_read;
    logic inc_write;
    logic inc_hit;
    logic inc_miss;

    always_comb begin
        inc_read  = 1'b0;
        inc_write = 1'b0;
        inc_hit   = 1'b0;
        inc_miss  = 1'b0;
        if (i_rsp_valid) begin
            inc_read  = cmd_is_read(i_cmd);          // data reads and fetches
            inc_write = (i_cmd == CMD_WRITE);
            if (cmd_is_access(i_cmd)) begin          // snoops and invalidates not counted
                inc_hit  = i_hit;
                inc_miss = !i_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_reads  <= '0;
            o_writes <= '0;
            o_hits   <= '0;
            o_misses <= '0;
        end else begin
            if (inc_read) o_reads <= o_reads + count_t'(1);
            if (inc_write) o_writes <= o_writes + count_t'(1);
            if (inc_hit) o_hits <= o_hits + count_t'(1);
            if (inc_miss) o_misses <= o_misses + count_t'(1);
        end
    end

endmodule

//--- verilog/cache_array.sv
// one set-associative tag array with MESI and LRU state that takes one command per i_req strobe
`timescale 1ns/100ps

module cache_array import cache_pkg::*; #(
    parameter int WAYS     = 8,
    parameter int SET_BITS = 4
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_req,
    input  logic                i_clear,
    input  cmd_t                i_cmd,
    input  logic [SET_BITS-1:0] i_set,
    input  line_tag_t           i_tag,
    output logic                o_rsp_valid,
    output logic                o_hit,
    output logic [2:0]          o_way,
    output mesi_t               o_mesi,
    output logic                o_evict,
    output logic                o_writeback
);

    localparam int SETS  = 1 << SET_BITS;
    localparam int LRU_W = $clog2(WAYS);

    typedef logic [WAYS-1:0][LRU_W-1:0] lru_row_t;

    line_tag_t [WAYS-1:0] tag_mem   [SETS];
    mesi_t     [WAYS-1:0] state_mem [SETS];
    lru_row_t             lru_mem   [SETS];

    line_tag_t [WAYS-1:0] set_tags;
    mesi_t     [WAYS-1:0] set_states;
    lru_row_t             set_lru;
    lru_row_t             new_lru;
    logic [LRU_W-1:0]     way;
    logic [LRU_W-1:0]     old_lru;
    logic                 hit;
    logic                 alloc;
    logic                 touch;
    logic                 update;
    logic                 line_wb;
    mesi_t                cur_state;
    mesi_t                next_state;

    // set read is combinational so a command on the next cycle sees this one's update
    assign set_tags   = tag_mem[i_set];
    assign set_states = state_mem[i_set];
    assign set_lru    = lru_mem[i_set];

    way_select #(.WAYS(WAYS)) u_way_select (
        .i_tag    (i_tag),
        .i_tags   (set_tags),
        .i_states (set_states),
        .i_lru    (set_lru),
        .o_hit    (hit),
        .o_way    (way)
    );

    assign cur_state = set_states[way];

    mesi_next u_mesi_next (
        .i_cmd       (i_cmd),
        .i_hit       (hit),
        .i_state     (cur_state),
        .o_state     (next_state),
        .o_writeback (line_wb),
        .o_alloc     (alloc)
    );

    assign update = hit || alloc;                            // line is written at all
    assign touch  = alloc || (hit && cmd_is_access(i_cmd));  // line becomes most recent

    // chosen way goes to the top, everything above its old position moves down
    always_comb begin
        old_lru = set_lru[way];
        for (int w = 0; w < WAYS; w++) begin
            if (LRU_W'(w) == way) begin
                new_lru[w] = LRU_W'(WAYS - 1);
            end else if (set_lru[w] > old_lru) begin
                new_lru[w] = set_lru[w] - 1'b1;
            end else begin
                new_lru[w] = set_lru[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_clear) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    state_mem[s][w] <= MESI_I;
                    lru_mem[s][w]   <= LRU_W'(w);   // way number is its starting age
                end
            end
        end else if (i_req) begin
            if (update) state_mem[i_set][way] <= next_state;
            if (touch)  lru_mem[i_set]        <= new_lru;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req && alloc) tag_mem[i_set][way] <= i_tag;
    end

    always_ff @(posedge clk) begin
        if (i_reset) o_rsp_valid <= 1'b0;
        else         o_rsp_valid <= i_req;
    end

    // response payload is valid with o_rsp_valid
    always_ff @(posedge clk) begin
        if (i_req) begin
            o_hit       <= hit;
            o_way       <= update ? 3'(way) : 3'd0;
            o_mesi      <= update ? next_state : MESI_I;
            o_evict     <= alloc && (cur_state != MESI_I);
            o_writeback <= line_wb || (alloc && cur_state == MESI_M);   // dirty victim leaves
        end
    end

endmodule

//--- verilog/mesi_next.sv
// next MESI state of the selected line plus snoop/invalidate write-back and allocate flags
`timescale 1ns/100ps

module mesi_next import cache_pkg::*; (
    input  cmd_t  i_cmd,
    input  logic  i_hit,
    input  mesi_t i_state,
    output mesi_t o_state,
    output logic  o_writeback,
    output logic  o_alloc
);

    // only processor accesses fill a line on a miss
    assign o_alloc = !i_hit && cmd_is_access(i_cmd);

    always_comb begin
        o_state     = i_state;     // default is no change
        o_writeback = 1'b0;
        case (i_cmd)
            CMD_READ, CMD_FETCH: begin
                if (!i_hit) o_state = MESI_E;   // no other sharers modelled
            end
            CMD_WRITE: begin
                o_state = MESI_M;
            end
            CMD_INVAL: begin
                if (i_hit) begin
                    o_state     = MESI_I;
                    o_writeback = (i_state == MESI_M);
                end
            end
            CMD_SNOOP_RD: begin
                if (i_hit) begin
                    if (i_state == MESI_M || i_state == MESI_E) begin
                        o_state = MESI_S;
                    end
                    o_writeback = (i_state == MESI_M);   // dirty data goes out on the snoop
                end
            end
            default: begin
                o_state = i_state;
            end
        endcase
    end

endmodule

//--- verilog/way_select.sv
// tag compare for one set that gives the hit way or the replacement victim inside cache_array
`timescale 1ns/100ps

module way_select import cache_pkg::*; #(
    parameter int WAYS = 8
) (
    input  line_tag_t                        i_tag,
    input  line_tag_t [WAYS-1:0]             i_tags,
    input  mesi_t     [WAYS-1:0]             i_states,
    input  logic      [WAYS-1:0][$clog2(WAYS)-1:0] i_lru,
    output logic                             o_hit,
    output logic      [$clog2(WAYS)-1:0]     o_way
);

    localparam int LRU_W = $clog2(WAYS);

    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] inv_vec;
    logic [WAYS-1:0] lru_zero;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w]  = (i_tags[w] == i_tag) && (i_states[w] != MESI_I);
            inv_vec[w]  = (i_states[w] == MESI_I);
            lru_zero[w] = (i_lru[w] == '0);
        end
    end

    assign o_hit = |hit_vec;

    // scanning downwards leaves the lowest set bit in o_way
    always_comb begin
        o_way = '0;
        if (|hit_vec) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (hit_vec[w]) o_way = LRU_W'(w);
            end
        end else if (|inv_vec) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (inv_vec[w]) o_way = LRU_W'(w);   // first free way
            end
        end else begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (lru_zero[w]) o_way = LRU_W'(w);  // least recently used
            end
        end
    end

endmodule

//--- verilog/cache_pkg.sv
// shared widths, command encoding and MESI states that the cache RTL and its testbench import
package cache_pkg;

    localparam int ADDR_W   = 32;              // byte address
    localparam int OFFSET_W = 6;               // 64-byte lines
    localparam int TAG_W    = ADDR_W - OFFSET_W;
    localparam int COUNT_W  = 32;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   line_tag_t;    // full line address, kept whole as the tag
    typedef logic [COUNT_W-1:0] count_t;

    // trace command codes
    typedef enum logic [3:0] {
        CMD_READ     = 4'd0,
        CMD_WRITE    = 4'd1,
        CMD_FETCH    = 4'd2,
        CMD_INVAL    = 4'd3,   // invalidate from L2
        CMD_SNOOP_RD = 4'd4,   // L2 snoops a read
        CMD_CLEAR    = 4'd8
    } cmd_t;

    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } mesi_t;

    // processor-side accesses are the only ones that allocate, touch LRU or count hit/miss
    function automatic logic cmd_is_access(cmd_t cmd);
        return (cmd == CMD_READ) || (cmd == CMD_WRITE) || (cmd == CMD_FETCH);
    endfunction

    // counted as reads
    function automatic logic cmd_is_read(cmd_t cmd);
        return (cmd == CMD_READ) || (cmd == CMD_FETCH);
    endfunction

    // commands served by the data array
    function automatic logic cmd_is_data(cmd_t cmd);
        logic data;
        case (cmd)
            CMD_READ,
            CMD_WRITE,
            CMD_INVAL,
            CMD_SNOOP_RD: data = 1'b1;
            default:      data = 1'b0;
        endcase
        return data;
    endfunction

endpackage
